//--- fabric_defs.svh
`ifndef FABRIC_DEFS_SVH
`define FABRIC_DEFS_SVH

////////////////////////////////////////
// Fabric geometry

// Ports on the crossbar, each one ingress and one egress
`define FABRIC_PORTS 4

////////////////////////////////////////
// Receive buffering

// 64-bit words per receive FIFO
`define FIFO_DEPTH 32
// Frame headers each FIFO can queue
`define HDR_DEPTH 4
// Longest frame in words
`define MAX_FRAME_WORDS 8

////////////////////////////////////////
// Address table

// Learned entries, replaced round robin
`define MAC_ENTRIES 16

`endif

//--- fabric_pkg.sv
`include "fabric_defs.svh"

package fabric_pkg;

	////////////////////////////////////////
	// Field widths

	typedef logic [47:0]                      mac_addr_t;
	typedef logic [11:0]                      vlan_id_t;
	typedef logic [$clog2(`FABRIC_PORTS)-1:0] port_id_t;
	// One bit per port
	typedef logic [`FABRIC_PORTS-1:0]         port_mask_t;
	typedef logic [63:0]                      data_word_t;

	////////////////////////////////////////
	// Frame side band and data path

	// Header fields sampled with the first word of a frame
	typedef struct packed {
		mac_addr_t dst_mac;
		mac_addr_t src_mac;
		vlan_id_t  vlan;
	} frame_hdr_t;

	typedef struct packed {
		data_word_t data;
		// Valid byte count, only meaningful with last set
		logic [3:0] bytes_valid;
		logic       last;
	} fabric_word_t;

	// Front of a receive FIFO as seen by scheduler and arbiter
	typedef struct packed {
		logic         frame_valid;
		frame_hdr_t   hdr;
		fabric_word_t word;
	} rx_fifo_bus_t;

	////////////////////////////////////////
	// Lookup and forwarding state

	typedef struct packed {
		port_id_t   src_port;
		frame_hdr_t hdr;
	} lookup_req_t;

	typedef struct packed {
		logic     hit;
		port_id_t dst_port;
	} lookup_rsp_t;

	// Where the frame at the front of a port goes
	typedef struct packed {
		logic     dst_valid;
		logic     broadcast;
		port_id_t dst_port;
	} port_state_t;

	typedef enum logic [1:0] {
		IDLE,
		UNICAST,
		FLOOD
	} arb_state_t;

endpackage

//--- rx_frame_fifo.sv
`include "fabric_defs.svh"

module rx_frame_fifo (
	input  logic                     clk,
	input  logic                     arst_n,
	input  logic                     wr,
	input  fabric_pkg::fabric_word_t word,
	input  fabric_pkg::frame_hdr_t   hdr,
	input  logic                     pop,
	output logic                     ready,
	output fabric_pkg::rx_fifo_bus_t bus
);
	import fabric_pkg::*;

	localparam int WORD_AW = $clog2(`FIFO_DEPTH);
	localparam int HDR_AW  = $clog2(`HDR_DEPTH);
	// Highest fill that still leaves room for a full length frame
	localparam logic [WORD_AW:0] FILL_LIMIT = (WORD_AW + 1)'(`FIFO_DEPTH - `MAX_FRAME_WORDS);

	////////////////////////////////////////
	// Word ring and header ring

	fabric_word_t word_mem [`FIFO_DEPTH];
	frame_hdr_t   hdr_mem  [`HDR_DEPTH];

	logic [WORD_AW-1:0] word_wr_ptr;
	logic [WORD_AW-1:0] word_rd_ptr;
	logic [WORD_AW:0]   word_count;
	logic [HDR_AW-1:0]  hdr_wr_ptr;
	logic [HDR_AW-1:0]  hdr_rd_ptr;
	// Headers held, including one for a frame still arriving
	logic [HDR_AW:0]    hdr_count;
	// Frames whose last word is already stored
	logic [HDR_AW:0]    frame_count;
	// Set between the first and last word of a frame
	logic               in_frame;

	logic         hdr_push;
	logic         frame_end;
	logic         frame_retire;
	fabric_word_t front;

	// Header goes in with the opening word
	assign hdr_push     = wr && !in_frame;
	assign frame_end    = wr && word.last;
	assign front        = word_mem[word_rd_ptr];
	// Last word leaving frees the header slot
	assign frame_retire = pop && front.last;

	always_ff @(posedge clk) begin
		if (wr)
			word_mem[word_wr_ptr] <= word;
		if (hdr_push)
			hdr_mem[hdr_wr_ptr] <= hdr;
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			word_wr_ptr <= '0;
			word_rd_ptr <= '0;
			word_count  <= '0;
			hdr_wr_ptr  <= '0;
			hdr_rd_ptr  <= '0;
			hdr_count   <= '0;
			frame_count <= '0;
			in_frame    <= 1'b0;
		end else begin
			if (wr)
				word_wr_ptr <= word_wr_ptr + 1'b1;
			if (pop)
				word_rd_ptr <= word_rd_ptr + 1'b1;
			if (hdr_push)
				hdr_wr_ptr <= hdr_wr_ptr + 1'b1;
			if (frame_retire)
				hdr_rd_ptr <= hdr_rd_ptr + 1'b1;
			// A single word frame opens and closes in one write
			if (wr)
				in_frame <= !word.last;
			word_count  <= word_count + (WORD_AW + 1)'(wr) - (WORD_AW + 1)'(pop);
			hdr_count   <= hdr_count + (HDR_AW + 1)'(hdr_push) - (HDR_AW + 1)'(frame_retire);
			frame_count <= frame_count + (HDR_AW + 1)'(frame_end) - (HDR_AW + 1)'(frame_retire);
		end
	end

	////////////////////////////////////////
	// Status toward source and fabric

	// Room for a whole frame plus a header slot
	assign ready = (word_count <= FILL_LIMIT) && (hdr_count < (HDR_AW + 1)'(`HDR_DEPTH));

	// Only complete frames are ever visible
	assign bus.frame_valid = frame_count != '0;
	assign bus.hdr         = hdr_mem[hdr_rd_ptr];
	assign bus.word        = front;

endmodule

//--- mac_table.sv
`include "fabric_defs.svh"

module mac_table (
	input  logic                    clk,
	input  logic                    arst_n,
	input  logic                    lookup_en,
	input  fabric_pkg::lookup_req_t req,
	output logic                    lookup_done,
	output fabric_pkg::lookup_rsp_t rsp
);
	import fabric_pkg::*;

	localparam int IDX_W = $clog2(`MAC_ENTRIES);

	////////////////////////////////////////
	// Entry storage

	logic [`MAC_ENTRIES-1:0] ent_valid;
	vlan_id_t                ent_vlan [`MAC_ENTRIES];
	mac_addr_t               ent_mac  [`MAC_ENTRIES];
	port_id_t                ent_port [`MAC_ENTRIES];
	// Next slot to overwrite when a new address arrives
	logic [IDX_W-1:0]        repl_ptr;

	logic             dst_hit;
	port_id_t         dst_port;
	logic             src_hit;
	logic [IDX_W-1:0] src_idx;
	logic             self_hit;

	logic     s1_valid;
	logic     s1_hit;
	port_id_t s1_port;

	////////////////////////////////////////
	// Stage 1 key match and learning

	// Both keys share the VLAN of the frame
	always_comb begin
		dst_hit  = 1'b0;
		dst_port = '0;
		src_hit  = 1'b0;
		src_idx  = '0;
		for (int i = 0; i < `MAC_ENTRIES; i++) begin
			if (ent_valid[i] && ent_vlan[i] == req.hdr.vlan) begin
				// Lowest matching entry wins
				if (!dst_hit && ent_mac[i] == req.hdr.dst_mac) begin
					dst_hit  = 1'b1;
					dst_port = ent_port[i];
				end
				if (!src_hit && ent_mac[i] == req.hdr.src_mac) begin
					src_hit = 1'b1;
					src_idx = IDX_W'(i);
				end
			end
		end
	end

	// Destination learned by this very request
	assign self_hit = req.hdr.dst_mac == req.hdr.src_mac;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ent_valid <= '0;
			repl_ptr  <= '0;
		end else if (lookup_en && !src_hit) begin
			ent_valid[repl_ptr] <= 1'b1;
			repl_ptr            <= repl_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (lookup_en) begin
			if (src_hit) begin
				// Known station, refresh its port in place
				ent_port[src_idx] <= req.src_port;
			end else begin
				ent_vlan[repl_ptr] <= req.hdr.vlan;
				ent_mac[repl_ptr]  <= req.hdr.src_mac;
				ent_port[repl_ptr] <= req.src_port;
			end
		end
		s1_hit  <= dst_hit || self_hit;
		s1_port <= self_hit ? req.src_port : dst_port;
		// Stage 2 response register
		rsp.hit      <= s1_hit;
		rsp.dst_port <= s1_port;
	end

	////////////////////////////////////////
	// Valid pipeline, two cycles

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			s1_valid    <= 1'b0;
			lookup_done <= 1'b0;
		end else begin
			s1_valid    <= lookup_en;
			lookup_done <= s1_valid;
		end
	end

endmodule

//--- forward_scheduler.sv
`include "fabric_defs.svh"

module forward_scheduler (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  fabric_pkg::rx_fifo_bus_t [`FABRIC_PORTS-1:0] fifo_bus,
	input  fabric_pkg::port_mask_t                      fifo_pop,
	output logic                                        lookup_en,
	output fabric_pkg::lookup_req_t                     req,
	input  logic                                        lookup_done,
	input  fabric_pkg::lookup_rsp_t                     rsp,
	output fabric_pkg::port_state_t [`FABRIC_PORTS-1:0]  port_state
);
	import fabric_pkg::*;

	// Port visited this cycle
	port_id_t   scan_port;
	// Source port of the lookups in flight
	port_id_t   port_d1;
	port_id_t   port_d2;
	// Ports with a lookup outstanding
	port_mask_t pending;

	////////////////////////////////////////
	// Lookup issue

	// Valid frame, no record yet and nothing in flight
	assign lookup_en = fifo_bus[scan_port].frame_valid
		&& !port_state[scan_port].dst_valid
		&& !pending[scan_port];

	assign req.src_port = scan_port;
	assign req.hdr      = fifo_bus[scan_port].hdr;

	// Source port follows the table latency
	always_ff @(posedge clk) begin
		port_d1 <= scan_port;
		port_d2 <= port_d1;
	end

	////////////////////////////////////////
	// Destination records

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			scan_port  <= '0;
			pending    <= '0;
			port_state <= '0;
		end else begin
			// Round robin over all ports, one per cycle
			if (scan_port == port_id_t'(`FABRIC_PORTS - 1))
				scan_port <= '0;
			else
				scan_port <= scan_port + 1'b1;

			// Record ends with the last word of its frame
			for (int p = 0; p < `FABRIC_PORTS; p++) begin
				if (fifo_pop[p] && fifo_bus[p].word.last)
					port_state[p].dst_valid <= 1'b0;
			end

			if (lookup_en)
				pending[scan_port] <= 1'b1;

			if (lookup_done) begin
				pending[port_d2] <= 1'b0;
				port_state[port_d2].dst_valid <= 1'b1;
				// Unknown destination floods
				port_state[port_d2].broadcast <= !rsp.hit;
				// Hit back to the source port means the frame is dropped
				port_state[port_d2].dst_port  <= rsp.hit ? rsp.dst_port : port_d2;
			end
		end
	end

endmodule

//--- crossbar_arbiter.sv
`include "fabric_defs.svh"

module crossbar_arbiter (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  fabric_pkg::rx_fifo_bus_t [`FABRIC_PORTS-1:0] fifo_bus,
	input  fabric_pkg::port_state_t  [`FABRIC_PORTS-1:0] port_state,
	output fabric_pkg::port_mask_t                      fifo_pop,
	output fabric_pkg::port_mask_t                      tx_valid,
	output fabric_pkg::fabric_word_t [`FABRIC_PORTS-1:0] tx_word
);
	import fabric_pkg::*;

	localparam int P = `FABRIC_PORTS;

	// Per source transfer state and the outputs it holds
	arb_state_t src_state [P];
	port_mask_t src_hold  [P];
	// Last unicast winner per output
	port_id_t   rr_ptr    [P];
	// Last flood winner
	port_id_t   flood_ptr;
	port_mask_t out_busy;

	port_mask_t cand;
	port_mask_t want_flood;
	port_mask_t want_drop;
	logic       flood_found;
	logic       flood_go;
	port_id_t   flood_src;
	port_mask_t flood_need;
	// Outputs kept free for a waiting flood
	port_mask_t reserved;
	port_mask_t uni_go;
	port_id_t   uni_src [P];

	port_mask_t                 out_fire;
	fabric_word_t [P-1:0]       out_word;

	////////////////////////////////////////
	// Request classification

	always_comb begin
		out_busy = '0;
		for (int s = 0; s < P; s++) begin
			out_busy |= src_hold[s];
			// Granted sources pop every cycle
			fifo_pop[s]   = src_state[s] != IDLE;
			cand[s]       = src_state[s] == IDLE && port_state[s].dst_valid
				&& fifo_bus[s].frame_valid;
			want_flood[s] = cand[s] && port_state[s].broadcast;
			want_drop[s]  = cand[s] && !port_state[s].broadcast
				&& port_state[s].dst_port == port_id_t'(s);
		end
	end

	////////////////////////////////////////
	// Flood grant

	always_comb begin
		port_id_t idx;
		flood_found = 1'b0;
		flood_src   = '0;
		for (int k = 1; k <= P; k++) begin
			idx = port_id_t'((int'(flood_ptr) + k) % P);
			if (!flood_found && want_flood[idx]) begin
				flood_found = 1'b1;
				flood_src   = idx;
			end
		end
		// Every output except the source
		flood_need = ~(port_mask_t'(1) << flood_src);
		flood_go   = flood_found && (out_busy & flood_need) == '0;
		reserved   = flood_found ? flood_need : '0;
	end

	////////////////////////////////////////
	// Unicast grant per output

	always_comb begin
		port_id_t idx;
		for (int o = 0; o < P; o++) begin
			uni_go[o]  = 1'b0;
			uni_src[o] = '0;
			// Search starts after the last winner
			for (int k = 1; k <= P; k++) begin
				idx = port_id_t'((int'(rr_ptr[o]) + k) % P);
				if (!uni_go[o] && cand[idx] && !port_state[idx].broadcast
					&& port_state[idx].dst_port == port_id_t'(o) && idx != port_id_t'(o)) begin
					uni_go[o]  = 1'b1;
					uni_src[o] = idx;
				end
			end
			uni_go[o] = uni_go[o] && !out_busy[o] && !reserved[o];
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			for (int s = 0; s < P; s++) begin
				src_state[s] <= IDLE;
				src_hold[s]  <= '0;
				rr_ptr[s]    <= port_id_t'(P - 1);
			end
			flood_ptr <= port_id_t'(P - 1);
		end else begin
			for (int s = 0; s < P; s++) begin
				if (fifo_pop[s] && fifo_bus[s].word.last) begin
					src_state[s] <= IDLE;
					src_hold[s]  <= '0;
				end else if (want_drop[s]) begin
					// Drained like a unicast that reaches no output
					src_state[s] <= UNICAST;
					src_hold[s]  <= '0;
				end
			end
			for (int o = 0; o < P; o++) begin
				if (uni_go[o]) begin
					src_state[uni_src[o]] <= UNICAST;
					src_hold[uni_src[o]]  <= port_mask_t'(1) << o;
					rr_ptr[o]             <= uni_src[o];
				end
			end
			if (flood_go) begin
				src_state[flood_src] <= FLOOD;
				src_hold[flood_src]  <= flood_need;
				flood_ptr            <= flood_src;
			end
		end
	end

	////////////////////////////////////////
	// Output word registers

	always_comb begin
		for (int o = 0; o < P; o++) begin
			out_fire[o] = 1'b0;
			out_word[o] = '0;
			for (int s = 0; s < P; s++) begin
				if (fifo_pop[s] && src_hold[s][o]) begin
					out_fire[o] = 1'b1;
					out_word[o] = fifo_bus[s].word;
				end
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			tx_valid <= '0;
		else
			tx_valid <= out_fire;
	end

	always_ff @(posedge clk) begin
		tx_word <= out_word;
	end

endmodule

//--- switch_fabric.sv
`include "fabric_defs.svh"

module switch_fabric (
	input  logic                                        clk,
	input  logic                                        arst_n,
	input  fabric_pkg::port_mask_t                      rx_wr,
	input  fabric_pkg::fabric_word_t [`FABRIC_PORTS-1:0] rx_word,
	input  fabric_pkg::frame_hdr_t   [`FABRIC_PORTS-1:0] rx_hdr,
	output fabric_pkg::port_mask_t                      rx_ready,
	output fabric_pkg::port_mask_t                      tx_valid,
	output fabric_pkg::fabric_word_t [`FABRIC_PORTS-1:0] tx_word
);
	import fabric_pkg::*;

	rx_fifo_bus_t [`FABRIC_PORTS-1:0] fifo_bus;
	port_mask_t                       fifo_pop;
	logic                             lookup_en;
	logic                             lookup_done;
	lookup_req_t                      lookup_req;
	lookup_rsp_t                      lookup_rsp;
	port_state_t  [`FABRIC_PORTS-1:0] port_state;

	////////////////////////////////////////
	// One receive FIFO per ingress port

	for (genvar p = 0; p < `FABRIC_PORTS; p++) begin : g_rx
		rx_frame_fifo u_fifo (
			.clk    (clk),
			.arst_n (arst_n),
			.wr     (rx_wr[p]),
			.word   (rx_word[p]),
			.hdr    (rx_hdr[p]),
			.pop    (fifo_pop[p]),
			.ready  (rx_ready[p]),
			.bus    (fifo_bus[p])
		);
	end

	////////////////////////////////////////
	// Lookup path and crossbar

	forward_scheduler u_sched (
		.clk         (clk),
		.arst_n      (arst_n),
		.fifo_bus    (fifo_bus),
		.fifo_pop    (fifo_pop),
		.lookup_en   (lookup_en),
		.req         (lookup_req),
		.lookup_done (lookup_done),
		.rsp         (lookup_rsp),
		.port_state  (port_state)
	);

	mac_table u_table (
		.clk         (clk),
		.arst_n      (arst_n),
		.lookup_en   (lookup_en),
		.req         (lookup_req),
		.lookup_done (lookup_done),
		.rsp         (lookup_rsp)
	);

	crossbar_arbiter u_arb (
		.clk        (clk),
		.arst_n     (arst_n),
		.fifo_bus   (fifo_bus),
		.port_state (port_state),
		.fifo_pop   (fifo_pop),
		.tx_valid   (tx_valid),
		.tx_word    (tx_word)
	);

endmodule

//--- switch_fabric_props.sv
`include "fabric_defs.svh"

module switch_fabric_props (
	input logic                                        clk,
	input logic                                        arst_n,
	input fabric_pkg::rx_fifo_bus_t [`FABRIC_PORTS-1:0] fifo_bus,
	input fabric_pkg::port_mask_t                      fifo_pop,
	input fabric_pkg::port_mask_t                      tx_valid,
	input fabric_pkg::port_mask_t                      src_hold [`FABRIC_PORTS]
);
	timeunit 1ns;
	timeprecision 100ps;
	import fabric_pkg::*;

	localparam int P = `FABRIC_PORTS;

	////////////////////////////////////////
	// Source side

	// A pop only ever removes a word of a complete frame
	for (genvar p = 0; p < P; p++) begin : g_pop
		pop_needs_frame: assert property (@(posedge clk) disable iff (!arst_n)
			fifo_pop[p] |-> fifo_bus[p].frame_valid)
			else $error("source %0d popped with no complete frame", p);
	end

	////////////////////////////////////////
	// Output ownership

	// Each output belongs to one source at most
	for (genvar s = 0; s < P; s++) begin : g_src
		for (genvar t = s + 1; t < P; t++) begin : g_other
			hold_disjoint: assert property (@(posedge clk) disable iff (!arst_n)
				(src_hold[s] & src_hold[t]) == '0)
				else $error("sources %0d and %0d hold the same output", s, t);
		end
	end

	// Egress stays quiet while reset is applied
	tx_quiet_in_reset: assert property (@(posedge clk)
		!arst_n |-> tx_valid == '0)
		else $error("tx_valid high during reset");

endmodule

bind crossbar_arbiter switch_fabric_props u_props (
	.clk      (clk),
	.arst_n   (arst_n),
	.fifo_bus (fifo_bus),
	.fifo_pop (fifo_pop),
	.tx_valid (tx_valid),
	.src_hold (src_hold)
);

//--- tb_switch_fabric.sv
`include "fabric_defs.svh"

module tb_switch_fabric;
	timeunit 1ns;
	timeprecision 100ps;
	import fabric_pkg::*;

	localparam int P           = `FABRIC_PORTS;
	localparam int CLK_PERIOD  = 8;
	localparam int NUM_FRAMES  = 40;
	// Per frame budget plus reset and idle padding
	localparam int WATCHDOG_CYCLES = NUM_FRAMES * (`MAX_FRAME_WORDS + 16) + 40;
	localparam int DRAIN_LIMIT = 400;

	localparam mac_addr_t MAC_A     = 48'h02_a0_00_00_00_0a;
	localparam mac_addr_t UNKNOWN_1 = 48'h02_ff_00_00_00_01;
	localparam mac_addr_t UNKNOWN_2 = 48'h02_ff_00_00_00_02;
	localparam mac_addr_t UNKNOWN_3 = 48'h02_ff_00_00_00_03;

	logic                     clk = 1'b0;
	logic                     arst_n;
	port_mask_t               rx_wr;
	fabric_word_t [P-1:0]     rx_word;
	frame_hdr_t   [P-1:0]     rx_hdr;
	port_mask_t               rx_ready;
	port_mask_t               tx_valid;
	fabric_word_t [P-1:0]     tx_word;

	// Expected words per output and source, index o * P + s
	fabric_word_t exp_q [P*P][$];
	// Reference table keyed by {vlan, mac}
	port_id_t     learned [logic [59:0]];
	logic [31:0]  rng_state = 32'h2e6f_3869;
	int           checks = 0;
	int           errors = 0;

	// Monitor state
	port_mask_t   in_frame = '0;
	port_id_t     cur_src [P];
	int           port3_low_cycles = 0;

	switch_fabric uut (
		.clk      (clk),
		.arst_n   (arst_n),
		.rx_wr    (rx_wr),
		.rx_word  (rx_word),
		.rx_hdr   (rx_hdr),
		.rx_ready (rx_ready),
		.tx_valid (tx_valid),
		.tx_word  (tx_word)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////
	// Helpers

	function automatic logic [31:0] next_random();
		logic [31:0] x;
		x = rng_state;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		rng_state = x;
		return x;
	endfunction

	function automatic frame_hdr_t make_hdr(mac_addr_t dst, mac_addr_t src, vlan_id_t vlan);
		frame_hdr_t h;
		h.dst_mac = dst;
		h.src_mac = src;
		h.vlan    = vlan;
		return h;
	endfunction

	function automatic mac_addr_t station_mac(int p);
		return 48'h02_00_00_00_00_10 + mac_addr_t'(p);
	endfunction

	// Learn the source first, then resolve the destination
	function automatic port_mask_t predict_dest(port_id_t src, frame_hdr_t hdr);
		logic [59:0] dkey;
		learned[{hdr.vlan, hdr.src_mac}] = src;
		dkey = {hdr.vlan, hdr.dst_mac};
		if (!learned.exists(dkey))
			return ~(port_mask_t'(1) << src);
		// Known station behind the source port is dropped
		if (learned[dkey] == src)
			return '0;
		return port_mask_t'(1) << learned[dkey];
	endfunction

	function automatic int pending_words();
		int n;
		n = 0;
		for (int i = 0; i < P * P; i++)
			n += exp_q[i].size();
		return n;
	endfunction

	task automatic check(input string what, input logic [127:0] got, input logic [127:0] expected);
		checks++;
		if (got !== expected) begin
			errors++;
			$display("[ERROR] t=%0t %s: got %0h, expected %0h", $time, what, got, expected);
		end
	endtask

	task automatic report_failure(input string msg);
		errors++;
		$display("t=%0t %s", $time, msg);
	endtask

	task automatic report_test(input string name, input int errors_before);
		if (errors == errors_before)
			$display("[TEST] %-12s ok", name);
		else
			$display("[TEST] %-12s %0d error(s)", name, errors - errors_before);
	endtask

	////////////////////////////////////////
	// Ingress driver

	task automatic send_frame(input int src, input frame_hdr_t hdr, input int len);
		fabric_word_t words [$];
		fabric_word_t w;
		port_mask_t   dest;
		for (int i = 0; i < len; i++) begin
			w.data        = {next_random(), next_random()};
			w.last        = (i == len - 1);
			w.bytes_valid = w.last ? 4'(1 + next_random() % 8) : 4'd0;
			// First word carries the source port for the monitor
			if (i == 0)
				w.data[49:48] = 2'(src);
			words.push_back(w);
		end
		dest = predict_dest(port_id_t'(src), hdr);
		for (int o = 0; o < P; o++) begin
			if (dest[o])
				foreach (words[i])
					exp_q[o * P + src].push_back(words[i]);
		end
		@(negedge clk);
		// Frame may start only with room for a full one
		while (!rx_ready[src])
			@(negedge clk);
		rx_hdr[src] = hdr;
		foreach (words[i]) begin
			rx_wr[src]   = 1'b1;
			rx_word[src] = words[i];
			@(negedge clk);
		end
		rx_wr[src] = 1'b0;
	endtask

	// Zero length asks for a random length
	task automatic send_burst(input int src, input frame_hdr_t hdr, input int count,
		input int len);
		int n;
		for (int i = 0; i < count; i++) begin
			n = (len == 0) ? 1 + int'(next_random() % `MAX_FRAME_WORDS) : len;
			send_frame(src, hdr, n);
		end
	endtask

	task automatic wait_drain();
		int cycles;
		cycles = 0;
		while ((pending_words() != 0 || in_frame != '0) && cycles < DRAIN_LIMIT) begin
			@(posedge clk);
			cycles++;
		end
		if (pending_words() != 0)
			report_failure($sformatf("%0d expected words never arrived", pending_words()));
		// Catch stray words after the last frame
		repeat (4) @(negedge clk);
	endtask

	////////////////////////////////////////
	// Egress monitors

	task automatic take_word(input int o, input int src, input fabric_word_t got);
		int idx;
		idx = o * P + src;
		if (exp_q[idx].size() == 0)
			report_failure($sformatf("output %0d sent a word no frame from port %0d expects",
				o, src));
		else
			check($sformatf("tx_word[%0d]", o), got, exp_q[idx].pop_front());
	endtask

	always @(negedge clk) begin
		if (arst_n) begin
			for (int o = 0; o < P; o++) begin
				if (tx_valid[o]) begin
					if (!in_frame[o])
						cur_src[o] = tx_word[o].data[49:48];
					take_word(o, cur_src[o], tx_word[o]);
					in_frame[o] = !tx_word[o].last;
				end else if (in_frame[o]) begin
					report_failure($sformatf("output %0d went idle inside a frame", o));
					in_frame[o] = 1'b0;
				end
			end
			if (!rx_ready[3])
				port3_low_cycles++;
		end
	end

	////////////////////////////////////////
	// Directed tests

	task automatic test_reset();
		int mark;
		mark = errors;
		arst_n = 1'b0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		check("tx_valid", tx_valid, '0);
		arst_n = 1'b1;
		@(negedge clk);
		check("tx_valid", tx_valid, '0);
		check("rx_ready", rx_ready, {P{1'b1}});
		report_test("reset", mark);
	endtask

	task automatic test_flood();
		int mark;
		mark = errors;
		send_frame(1, make_hdr(UNKNOWN_1, station_mac(1), 12'd10), 5);
		wait_drain();
		report_test("flood", mark);
	endtask

	task automatic test_learning();
		int mark;
		mark = errors;
		// Station A announces itself from port 2
		send_frame(2, make_hdr(UNKNOWN_2, MAC_A, 12'd10), 3);
		wait_drain();
		send_frame(0, make_hdr(MAC_A, station_mac(0), 12'd10), 6);
		wait_drain();
		report_test("learning", mark);
	endtask

	task automatic test_vlan();
		int mark;
		mark = errors;
		send_frame(0, make_hdr(MAC_A, station_mac(0), 12'd20), 4);
		wait_drain();
		report_test("vlan_key", mark);
	endtask

	task automatic test_contention();
		int mark;
		mark = errors;
		fork
			send_burst(0, make_hdr(MAC_A, station_mac(0), 12'd10), 4, 0);
			send_burst(1, make_hdr(MAC_A, station_mac(1), 12'd10), 4, 0);
			send_burst(3, make_hdr(MAC_A, station_mac(3), 12'd10), 4, 0);
		join
		wait_drain();
		report_test("contention", mark);
	endtask

	task automatic test_backpressure();
		int mark;
		int low_before;
		mark       = errors;
		low_before = port3_low_cycles;
		// Ports 0 and 1 keep output 2 busy while port 3 floods
		fork
			send_burst(0, make_hdr(MAC_A, station_mac(0), 12'd10), 6, `MAX_FRAME_WORDS);
			send_burst(1, make_hdr(MAC_A, station_mac(1), 12'd10), 6, `MAX_FRAME_WORDS);
			send_burst(3, make_hdr(UNKNOWN_3, station_mac(3), 12'd10), 12, `MAX_FRAME_WORDS);
		join
		wait_drain();
		check("rx_ready[3] dropped", port3_low_cycles > low_before, 1'b1);
		check("rx_ready", rx_ready, {P{1'b1}});
		report_test("backpressure", mark);
	endtask

	////////////////////////////////////////
	// Sequence and watchdog

	initial begin
		arst_n  = 1'b0;
		rx_wr   = '0;
		rx_word = '0;
		rx_hdr  = '0;
		test_reset();
		test_flood();
		test_learning();
		test_vlan();
		test_contention();
		test_backpressure();
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0)
			$display("ALL CHECKS PASSED");
		else
			$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("timeout, run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

//--- switch_fabric.f
+incdir+.
fabric_pkg.sv
rx_frame_fifo.sv
mac_table.sv
forward_scheduler.sv
crossbar_arbiter.sv
switch_fabric.sv
switch_fabric_props.sv
tb_switch_fabric.sv

//--- Makefile
# Verilator build and run for the switch fabric testbench

VERILATOR  ?= verilator
TOP        ?= tb_switch_fabric
RTL_TOP    ?= switch_fabric
FILELIST   ?= switch_fabric.f
OBJ_DIR    ?= obj_dir
TIMESCALE  ?= 1ns/1ps
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_TEXT  ?= ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --timescale $(TIMESCALE) --top-module $(TOP) \
		-Mdir $(OBJ_DIR) -f $(FILELIST)

# Pass only when the simulation printed the pass line
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --timescale $(TIMESCALE) --top-module $(RTL_TOP) \
		-f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
